// File: flist.f
common/armPkg.sv
datapath/pipeReg.sv
datapath/regFile.sv
datapath/barrelShifter.sv
datapath/memFormat.sv
datapath/datapath.sv
design/decoder.sv
design/hazardUnit.sv
design/armPipeTop.sv
test/armPipeTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module armPipeTb -f flist.f -o armPipeSim

out=$(./obj_dir/armPipeSim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// File: test/armPipeTb.sv
`timescale 1ns/1ps

module armPipeTb;
  import armPkg::*;

  localparam logic [31:0] ResetPc = 32'h0000_0040;

  logic        clk = 1'b0;
  logic        rstN = 1'b0;
  logic [31:0] instrAddr, instr;
  logic [31:0] dataAddr, writeData, readData;
  logic [3:0]  byteEnable;
  logic        memWrite;

  // Memory models, 1 KB each, combinational read
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  // ISA-level model state
  logic [31:0] regModel [0:15];
  logic [31:0] memModel [0:255];
  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [3:0]  expBe [$];
  logic [31:0] logAddr [$];
  logic [31:0] logData [$];
  logic [3:0]  logBe [$];
  logic [31:0] haltAddr;
  logic [31:0] lfsr = 32'h4a57_9af3;

  int errorCount = 0;
  int checkCount = 0;
  int budget = 200;
  int cyclesUsed = 0;

  logic [3:0] dpOps [8] = '{AluAnd, AluEor, AluSub, AluRsb, AluAdd, AluOrr, AluMov, AluBic};
  logic [3:0] randOps [3] = '{AluAdd, AluSub, AluEor};

  armPipeTop #(.ResetPc(ResetPc)) i_armPipeTop (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .dataAddr(dataAddr),
    .writeData(writeData), .byteEnable(byteEnable), .memWrite(memWrite), .readData(readData)
  );

  always #4 clk = ~clk;

  assign instr    = imem[instrAddr[9:2]];
  assign readData = dmem[dataAddr[9:2]];

  // Byte lanes to a 32-bit mask
  function automatic logic [31:0] laneMask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Data memory write, only enabled lanes change
  always @(posedge clk) begin
    if (memWrite === 1'b1) begin
      dmem[dataAddr[9:2]] <= (dmem[dataAddr[9:2]] & ~laneMask(byteEnable)) |
                             (writeData & laneMask(byteEnable));
    end
  end

  // Store log, sampled mid-cycle
  always @(negedge clk) begin
    if (rstN === 1'b1 && memWrite === 1'b1) begin
      logAddr.push_back(dataAddr);
      logData.push_back(writeData & laneMask(byteEnable));
      logBe.push_back(byteEnable);
    end
  end

  // Watchdog, budget grows with each loaded program
  initial begin
    while (cyclesUsed <= budget) begin
      @(posedge clk);
      cyclesUsed++;
    end
    $display("Timeout after %0d cycles, a program never reached its halt address", cyclesUsed);
    $display("TEST FAILED");
    $finish;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [31:0] rotateRight(input logic [31:0] v, input int n);
    if (n % 32 == 0) begin
      return v;
    end
    return (v >> (n % 32)) | (v << (32 - n % 32));
  endfunction

  // LSR/ASR #0 mean 32, ROR #0 means no shift
  function automatic logic [31:0] shiftValue(input logic [31:0] v, input int sh, input int amt);
    logic [31:0] r;
    int          k;
    r = v;
    k = (amt == 0) ? 32 : amt;
    case (sh)
      0: r = v << amt;
      1: r = (amt == 0) ? 32'd0 : v >> amt;
      2: begin
        for (int i = 0; i < k; i++) begin
          r = {r[31], r[31:1]};
        end
      end
      default: r = rotateRight(v, amt);
    endcase
    return r;
  endfunction

  function automatic logic [31:0] aluResult(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      AluAnd:  return a & b;
      AluEor:  return a ^ b;
      AluSub:  return a - b;
      AluRsb:  return b - a;
      AluAdd:  return a + b;
      AluOrr:  return a | b;
      AluMov:  return b;
      AluBic:  return a & ~b;
      default: return a;
    endcase
  endfunction

  // R15 reads as the address of the next slot plus 8
  function automatic logic [31:0] regValue(input int r);
    if (r == 15) begin
      return ResetPc + 32'(4 * prog.size()) + 32'd8;
    end
    return regModel[r];
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // ========================================
  // Instruction encoders and builders
  // ========================================
  function automatic logic [31:0] dpImmWord(input logic [3:0] op, input int rd, input int rn,
                                            input int rot, input int imm8);
    return {4'hE, 3'b001, op, 1'b0, rn[3:0], rd[3:0], rot[3:0], imm8[7:0]};
  endfunction

  function automatic logic [31:0] dpRegWord(input logic [3:0] op, input int rd, input int rn,
                                            input int rm, input int sh, input int amt);
    return {4'hE, 3'b000, op, 1'b0, rn[3:0], rd[3:0], amt[4:0], sh[1:0], 1'b0, rm[3:0]};
  endfunction

  // Pre-indexed, no writeback
  function automatic logic [31:0] memWord(input logic load, input logic byteAcc, input logic up,
                                          input int rd, input int rn, input int off);
    return {4'hE, 3'b010, 1'b1, up, byteAcc, 1'b0, load, rn[3:0], rd[3:0], off[11:0]};
  endfunction

  task automatic aluImm(input logic [3:0] op, input int rd, input int rn, input int rot,
                        input int imm8);
    logic [31:0] b;
    b = rotateRight({24'd0, imm8[7:0]}, 2 * rot);
    regModel[rd] = aluResult(op, regValue(rn), b);
    prog.push_back(dpImmWord(op, rd, rn, rot, imm8));
  endtask

  task automatic aluShifted(input logic [3:0] op, input int rd, input int rn, input int rm,
                            input int sh, input int amt);
    regModel[rd] = aluResult(op, regValue(rn), shiftValue(regValue(rm), sh, amt));
    prog.push_back(dpRegWord(op, rd, rn, rm, sh, amt));
  endtask

  task automatic storeInstr(input logic byteAcc, input int rd, input int rn, input logic up,
                            input int off);
    logic [31:0] addr, val, data;
    logic [3:0]  be;
    addr = up ? regValue(rn) + off : regValue(rn) - off;
    val  = regValue(rd);
    be   = byteAcc ? (4'b0001 << addr[1:0]) : 4'hF;
    data = byteAcc ? {4{val[7:0]}} : val;
    expAddr.push_back({addr[31:2], 2'b00});
    expData.push_back(data & laneMask(be));
    expBe.push_back(be);
    memModel[addr[9:2]] = (memModel[addr[9:2]] & ~laneMask(be)) | (data & laneMask(be));
    prog.push_back(memWord(1'b0, byteAcc, up, rd, rn, off));
  endtask

  task automatic loadInstr(input logic byteAcc, input int rd, input int rn, input logic up,
                           input int off);
    logic [31:0] addr, word;
    addr = up ? regValue(rn) + off : regValue(rn) - off;
    word = memModel[addr[9:2]];
    // Byte loads zero-extend
    regModel[rd] = byteAcc ? (word >> (8 * addr[1:0])) & 32'hFF : word;
    prog.push_back(memWord(1'b1, byteAcc, up, rd, rn, off));
  endtask

  // B skipping the next slots, each filled with a store that must never run
  task automatic branchOver(input int skip);
    int off;
    off = skip - 1;
    prog.push_back({4'hE, 3'b101, 1'b0, off[23:0]});
    for (int i = 0; i < skip; i++) begin
      prog.push_back(memWord(1'b0, 1'b0, 1'b1, 1, 13, 'h40 + 4 * i));
    end
  endtask

  // ========================================
  // Run control and checks
  // ========================================
  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAILED %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic newProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
    expBe.delete();
    for (int i = 0; i < 256; i++) begin
      memModel[i] = '0;
    end
  endtask

  // Reset held for 3 edges, memWrite watched throughout
  task automatic applyReset();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      checkValue("reset memWrite", 32'd0, 32'(memWrite));
    end
    rstN = 1'b1;
    checkValue("reset instrAddr", ResetPc, instrAddr);
  endtask

  task automatic startProgram();
    // Zero words decode as AND R0,R0,R0 which changes nothing
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] <= '0;
    end
    foreach (prog[i]) begin
      imem[ResetPc[9:2] + i] = prog[i];
    end
    haltAddr = ResetPc + 32'(4 * prog.size());
    budget += prog.size() * 8;
    logAddr.delete();
    logData.delete();
    logBe.delete();
    applyReset();
  endtask

  task automatic compareStores(input string name);
    checkValue($sformatf("%s store count", name), 32'(expAddr.size()), 32'(logAddr.size()));
    for (int i = 0; i < expAddr.size() && i < logAddr.size(); i++) begin
      checkValue($sformatf("%s store %0d addr", name, i), expAddr[i], logAddr[i]);
      checkValue($sformatf("%s store %0d data", name, i), expData[i], logData[i]);
      checkValue($sformatf("%s store %0d byteEnable", name, i), 32'(expBe[i]), 32'(logBe[i]));
    end
  endtask

  // Fetch reaches or passes the halt address, then the tail drains
  task automatic finishProgram(input string name);
    while ($isunknown(instrAddr) || instrAddr < haltAddr) begin
      @(posedge clk);
      #1;
    end
    repeat (6) begin
      @(posedge clk);
      #1;
    end
    compareStores(name);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic resetTest();
    newProgram();
    aluImm(AluMov, 3, 0, 0, 'h21);
    aluImm(AluMov, 13, 0, 12, 'h02);
    storeInstr(1'b0, 3, 13, 1'b1, 0);
    startProgram();
    // Store in slot 2 reaches memory after the fifth edge
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      checkValue("reset early memWrite", 32'd0, 32'(memWrite));
      if (i == 0) begin
        checkValue("reset second instrAddr", ResetPc + 32'd4, instrAddr);
      end
    end
    finishProgram("reset");
  endtask

  task automatic dpImmediateTest();
    newProgram();
    aluImm(AluMov, 13, 0, 12, 'h02);
    // 0xFF rotated by 8
    aluImm(AluMov, 1, 0, 4, 'hFF);
    aluImm(AluOrr, 1, 1, 0, 'h3C);
    for (int i = 0; i < 8; i++) begin
      aluImm(dpOps[i], 2, 1, (3 * i + 1) % 16, ('h5A + 23 * i) % 256);
      storeInstr(1'b0, 2, 13, 1'b1, 4 * i);
    end
    startProgram();
    finishProgram("dp immediate");
  endtask

  // Each op reads the two previous results, memory and writeback bypass
  task automatic shiftForwardTest();
    newProgram();
    aluImm(AluMov, 13, 0, 12, 'h03);
    aluImm(AluMov, 1, 0, 4, 'h8F);
    aluShifted(AluAdd, 2, 1, 1, 0, 4);
    aluShifted(AluEor, 3, 2, 1, 2, 0);
    aluShifted(AluSub, 4, 3, 2, 1, 7);
    aluShifted(AluAdd, 5, 4, 1, 1, 0);
    aluShifted(AluRsb, 6, 5, 3, 3, 0);
    aluShifted(AluBic, 7, 6, 2, 3, 12);
    aluShifted(AluOrr, 8, 7, 5, 2, 3);
    aluShifted(AluAnd, 9, 8, 7, 0, 31);
    for (int r = 2; r <= 9; r++) begin
      storeInstr(1'b0, r, 13, 1'b1, 4 * r);
    end
    startProgram();
    finishProgram("shift forward");
  endtask

  task automatic loadStoreTest();
    newProgram();
    aluImm(AluMov, 13, 0, 12, 'h01);
    aluImm(AluMov, 1, 0, 2, 'hAB);
    aluImm(AluMov, 2, 0, 0, 'h71);
    storeInstr(1'b0, 1, 13, 1'b1, 8);
    loadInstr(1'b0, 3, 13, 1'b1, 8);
    // Load-use stall
    aluShifted(AluAdd, 4, 3, 2, 0, 0);
    storeInstr(1'b0, 4, 13, 1'b1, 12);
    // Down offset
    storeInstr(1'b0, 2, 13, 1'b0, 4);
    loadInstr(1'b0, 5, 13, 1'b0, 4);
    storeInstr(1'b0, 5, 13, 1'b1, 0);
    // Byte stores to every lane
    for (int k = 0; k < 4; k++) begin
      aluImm(AluMov, 6, 0, 0, 'h80 + 'h11 * k);
      storeInstr(1'b1, 6, 13, 1'b1, 16 + k);
    end
    loadInstr(1'b1, 7, 13, 1'b1, 17);
    loadInstr(1'b1, 8, 13, 1'b1, 19);
    aluShifted(AluAdd, 9, 7, 8, 0, 0);
    storeInstr(1'b0, 9, 13, 1'b1, 20);
    storeInstr(1'b0, 7, 13, 1'b1, 24);
    startProgram();
    finishProgram("load store");
  endtask

  task automatic branchTest();
    newProgram();
    aluImm(AluMov, 13, 0, 13, 'h06);
    aluImm(AluMov, 1, 0, 0, 'h11);
    branchOver(3);
    // Landing address shows up as PC+8
    aluShifted(AluMov, 5, 0, 15, 0, 0);
    storeInstr(1'b0, 5, 13, 1'b1, 0);
    storeInstr(1'b0, 1, 13, 1'b1, 4);
    branchOver(2);
    storeInstr(1'b0, 13, 13, 1'b1, 8);
    startProgram();
    finishProgram("branch");
  endtask

  task automatic randomChainTest();
    int rd;
    int rn;
    newProgram();
    aluImm(AluMov, 13, 0, 13, 'h0A);
    for (int r = 1; r <= 6; r++) begin
      aluImm(AluMov, r, 0, randBits(4), randBits(8));
    end
    for (int i = 0; i < 24; i++) begin
      rd = 1 + randBits(3) % 6;
      rn = 1 + randBits(3) % 6;
      aluImm(randOps[randBits(2) % 3], rd, rn, randBits(4), randBits(8));
    end
    for (int r = 1; r <= 6; r++) begin
      storeInstr(1'b0, r, 13, 1'b1, 4 * r);
    end
    startProgram();
    finishProgram("random chain");
  endtask

  initial begin
    resetTest();
    dpImmediateTest();
    shiftForwardTest();
    loadStoreTest();
    branchTest();
    randomChainTest();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/armPipeTop.sv
`timescale 1ns/1ps

module armPipeTop #(
  parameter logic [31:0] ResetPc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] instrAddr,
  input  logic [31:0] instr,
  output logic [31:0] dataAddr,
  output logic [31:0] writeData,
  output logic [3:0]  byteEnable,
  output logic        memWrite,
  input  logic [31:0] readData
);

  logic [31:0]     instrD;
  armPkg::ctrlT    ctrlD;
  armPkg::regAddrT ra1D, ra2D, waD;
  armPkg::regAddrT ra1E, ra2E, waE, waM, waW;
  logic            regWriteM, regWriteW, memToRegE, branchTakenE;
  logic [1:0]      forwardA, forwardB;
  logic            stallF, stallD, flushD, flushE;

  // Control word and register numbers for the decode stage
  decoder dec (
    .instrD(instrD), .ctrlD(ctrlD), .ra1D(ra1D), .ra2D(ra2D), .waD(waD)
  );

  // Bypass, load-use stall and branch squash
  hazardUnit hzd (
    .ra1D(ra1D), .ra2D(ra2D), .ra1E(ra1E), .ra2E(ra2E), .waE(waE), .waM(waM), .waW(waW),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .memToRegE(memToRegE),
    .branchTakenE(branchTakenE), .forwardA(forwardA), .forwardB(forwardB),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

  datapath #(.ResetPc(ResetPc)) dp (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .instrD(instrD),
    .ctrlD(ctrlD), .ra1D(ra1D), .ra2D(ra2D), .waD(waD),
    .forwardA(forwardA), .forwardB(forwardB),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .ra1E(ra1E), .ra2E(ra2E), .waE(waE), .waM(waM), .waW(waW),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .memToRegE(memToRegE),
    .branchTakenE(branchTakenE), .dataAddr(dataAddr), .writeData(writeData),
    .byteEnable(byteEnable), .memWrite(memWrite), .readData(readData)
  );

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  armPkg::regAddrT       ra1D,
  input  armPkg::regAddrT       ra2D,
  input  armPkg::regAddrT       ra1E,
  input  armPkg::regAddrT       ra2E,
  input  armPkg::regAddrT       waE,
  input  armPkg::regAddrT       waM,
  input  armPkg::regAddrT       waW,
  input  logic                  regWriteM,
  input  logic                  regWriteW,
  input  logic                  memToRegE,
  input  logic                  branchTakenE,
  output logic            [1:0] forwardA,
  output logic            [1:0] forwardB,
  output logic                  stallF,
  output logic                  stallD,
  output logic                  flushD,
  output logic                  flushE
);
  import armPkg::*;

  logic loadUse;

  // Forward select
  // 2'b10 memory ALU result, 2'b01 writeback result, else register file
  // Memory stage is younger so it wins, R15 always comes from the register file
  assign forwardA = (regWriteM && waM == ra1E && ra1E != PcReg) ? 2'b10 :
                    (regWriteW && waW == ra1E && ra1E != PcReg) ? 2'b01 : 2'b00;
  assign forwardB = (regWriteM && waM == ra2E && ra2E != PcReg) ? 2'b10 :
                    (regWriteW && waW == ra2E && ra2E != PcReg) ? 2'b01 : 2'b00;

  // Load in execute feeding the instruction in decode
  assign loadUse = memToRegE && (waE == ra1D || waE == ra2D);

  assign stallF = loadUse;
  assign stallD = loadUse;

  // Taken branch squashes decode and execute
  assign flushD = branchTakenE;
  assign flushE = branchTakenE || loadUse;

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  logic            [31:0] instrD,
  output armPkg::ctrlT           ctrlD,
  output armPkg::regAddrT        ra1D,
  output armPkg::regAddrT        ra2D,
  output armPkg::regAddrT        waD
);
  import armPkg::*;

  logic dpOpOk;

  // Opcodes outside the subset decode as no-ops
  always_comb begin
    case (instrD[24:21])
      AluAnd, AluEor, AluSub, AluRsb,
      AluAdd, AluOrr, AluMov, AluBic: dpOpOk = 1'b1;
      default:                        dpOpOk = 1'b0;
    endcase
  end

  always_comb begin
    // Default field positions, Rn / Rm / Rd
    ctrlD = '0;
    ra1D  = regAddrT'(instrD[19:16]);
    ra2D  = regAddrT'(instrD[3:0]);
    waD   = regAddrT'(instrD[15:12]);
    case (instrD[27:25])
      // Data processing
      // bit4 set with a register operand is a register shift, MUL or halfword
      3'b000, 3'b001: begin
        if (dpOpOk && !(!instrD[25] && instrD[4])) begin
          ctrlD.regWrite   = 1'b1;
          ctrlD.immOperand = instrD[25];
          ctrlD.aluOp      = aluOpT'(instrD[24:21]);
        end
      end
      // Single data transfer, immediate offset
      // Only P=1, W=0 is handled
      3'b010: begin
        if (instrD[24] && !instrD[21]) begin
          ctrlD.memOffset  = 1'b1;
          ctrlD.offsetUp   = instrD[23];
          ctrlD.byteAccess = instrD[22];
          ctrlD.aluOp      = AluAdd;
          if (instrD[20]) begin
            ctrlD.regWrite = 1'b1;
            ctrlD.memToReg = 1'b1;
          end else begin
            // Store data comes from Rd on the second read port
            ctrlD.memWrite = 1'b1;
            ra2D           = regAddrT'(instrD[15:12]);
          end
        end
      end
      // B without link
      3'b101: begin
        ctrlD.branch = !instrD[24];
      end
      default: begin
        ctrlD = '0;
      end
    endcase
  end

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath #(
  parameter logic [31:0] ResetPc = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rstN,
  output logic            [31:0] instrAddr,
  input  logic            [31:0] instr,
  output logic            [31:0] instrD,
  input  armPkg::ctrlT           ctrlD,
  input  armPkg::regAddrT        ra1D,
  input  armPkg::regAddrT        ra2D,
  input  armPkg::regAddrT        waD,
  input  logic            [1:0]  forwardA,
  input  logic            [1:0]  forwardB,
  input  logic                   stallF,
  input  logic                   stallD,
  input  logic                   flushD,
  input  logic                   flushE,
  output armPkg::regAddrT        ra1E,
  output armPkg::regAddrT        ra2E,
  output armPkg::regAddrT        waE,
  output armPkg::regAddrT        waM,
  output armPkg::regAddrT        waW,
  output logic                   regWriteM,
  output logic                   regWriteW,
  output logic                   memToRegE,
  output logic                   branchTakenE,
  output logic            [31:0] dataAddr,
  output logic            [31:0] writeData,
  output logic            [3:0]  byteEnable,
  output logic                   memWrite,
  input  logic            [31:0] readData
);
  import armPkg::*;

  logic [31:0] pcF, pcPlus4F, pcNextF;
  logic [31:0] rd1D, rd2D, immD;
  execStageT   execD, execE;
  memStageT    memE, memM;
  wbStageT     wbM, wbW;
  logic [31:0] srcAE, srcBRegE, shiftInE, shiftOutE;
  logic [31:0] aluResultE, addrE, targetE;
  logic [31:0] loadDataM;
  logic [31:0] resultW;

  function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] regVal,
                                         input logic [31:0] wbVal, input logic [31:0] memVal);
    case (sel)
      2'b01:   return wbVal;
      2'b10:   return memVal;
      default: return regVal;
    endcase
  endfunction

  // ========================================
  // Fetch
  // ========================================
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = branchTakenE ? targetE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= ResetPc;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  assign instrAddr = pcF;

  // A cleared word is AND R0,R0,R0 which changes nothing
  pipeReg #(.payloadT(logic [31:0])) decodeReg (
    .clk(clk), .rstN(rstN), .en(!stallD), .clr(flushD), .d(instr), .q(instrD)
  );

  // ========================================
  // Decode
  // ========================================
  // Fetch PC is one word past decode, so PC+4 of fetch is PC+8 of decode
  regFile rf (
    .clk(clk), .we(wbW.ctrl.regWrite), .ra1(ra1D), .ra2(ra2D), .wa(wbW.wa),
    .wd(resultW), .pcPlus8(pcPlus4F), .rd1(rd1D), .rd2(rd2D)
  );

  // Branch offset is word scaled and sign extended
  assign immD = ctrlD.branch ? {{6{instrD[23]}}, instrD[23:0], 2'b00} : {20'd0, instrD[11:0]};

  always_comb begin
    execD.ctrl      = ctrlD;
    execD.rd1       = rd1D;
    execD.rd2       = rd2D;
    execD.imm       = immD;
    execD.ra1       = ra1D;
    execD.ra2       = ra2D;
    execD.wa        = waD;
    execD.shiftType = shiftT'(instrD[6:5]);
    execD.shiftAmt  = instrD[11:7];
    execD.pcPlus8   = pcPlus4F;
  end

  pipeReg #(.payloadT(execStageT)) execReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clr(flushE), .d(execD), .q(execE)
  );

  // ========================================
  // Execute
  // ========================================
  assign ra1E         = execE.ra1;
  assign ra2E         = execE.ra2;
  assign waE          = execE.wa;
  assign memToRegE    = execE.ctrl.memToReg;
  assign branchTakenE = execE.ctrl.branch;

  // Bypass from memory ALU result or writeback result
  assign srcAE    = fwdMux(forwardA, execE.rd1, resultW, memM.aluOut);
  assign srcBRegE = fwdMux(forwardB, execE.rd2, resultW, memM.aluOut);

  // Operand 2, immediate form rotates the raw 12-bit field
  assign shiftInE = execE.ctrl.immOperand ? execE.imm : srcBRegE;

  barrelShifter shifter (
    .value(shiftInE), .shiftType(execE.shiftType), .amount(execE.shiftAmt),
    .immForm(execE.ctrl.immOperand), .result(shiftOutE)
  );

  always_comb begin
    case (execE.ctrl.aluOp)
      AluAnd:  aluResultE = srcAE & shiftOutE;
      AluEor:  aluResultE = srcAE ^ shiftOutE;
      AluSub:  aluResultE = srcAE - shiftOutE;
      AluRsb:  aluResultE = shiftOutE - srcAE;
      AluAdd:  aluResultE = srcAE + shiftOutE;
      AluOrr:  aluResultE = srcAE | shiftOutE;
      AluMov:  aluResultE = shiftOutE;
      AluBic:  aluResultE = srcAE & ~shiftOutE;
      default: aluResultE = 32'd0;
    endcase
  end

  // Pre-indexed address, no writeback
  assign addrE   = execE.ctrl.offsetUp ? srcAE + execE.imm : srcAE - execE.imm;
  assign targetE = execE.pcPlus8 + execE.imm;

  always_comb begin
    memE.ctrl      = execE.ctrl;
    memE.aluOut    = execE.ctrl.memOffset ? addrE : aluResultE;
    memE.writeData = srcBRegE;
    memE.wa        = execE.wa;
  end

  pipeReg #(.payloadT(memStageT)) memReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clr(1'b0), .d(memE), .q(memM)
  );

  // ========================================
  // Memory
  // ========================================
  assign waM       = memM.wa;
  assign regWriteM = memM.ctrl.regWrite;
  assign memWrite  = memM.ctrl.memWrite;
  assign dataAddr  = {memM.aluOut[31:2], 2'b00};

  memFormat fmt (
    .byteAccess(memM.ctrl.byteAccess), .addrLow(memM.aluOut[1:0]),
    .storeData(memM.writeData), .rawRead(readData), .laneData(writeData),
    .byteEnable(byteEnable), .loadData(loadDataM)
  );

  always_comb begin
    wbM.ctrl     = memM.ctrl;
    wbM.aluOut   = memM.aluOut;
    wbM.readData = loadDataM;
    wbM.wa       = memM.wa;
  end

  pipeReg #(.payloadT(wbStageT)) wbReg (
    .clk(clk), .rstN(rstN), .en(1'b1), .clr(1'b0), .d(wbM), .q(wbW)
  );

  // ========================================
  // Writeback
  // ========================================
  assign waW       = wbW.wa;
  assign regWriteW = wbW.ctrl.regWrite;
  assign resultW   = wbW.ctrl.memToReg ? wbW.readData : wbW.aluOut;

endmodule

// File: datapath/memFormat.sv
`timescale 1ns/1ps

module memFormat (
  input  logic        byteAccess,
  input  logic [1:0]  addrLow,
  input  logic [31:0] storeData,
  input  logic [31:0] rawRead,
  output logic [31:0] laneData,
  output logic [3:0]  byteEnable,
  output logic [31:0] loadData
);

  logic [7:0] loadByte;

  // ========================================
  // Store side
  // ========================================
  // Byte stores put the low byte on every lane
  assign laneData = byteAccess ? {4{storeData[7:0]}} : storeData;

  // One-hot lane for bytes, full word otherwise
  assign byteEnable = byteAccess ? (4'b0001 << addrLow) : 4'b1111;

  // ========================================
  // Load side
  // ========================================
  // Lane 0 is the lowest address, little endian
  always_comb begin
    case (addrLow)
      2'd0:    loadByte = rawRead[7:0];
      2'd1:    loadByte = rawRead[15:8];
      2'd2:    loadByte = rawRead[23:16];
      default: loadByte = rawRead[31:24];
    endcase
  end

  // LDRB zero-extends
  assign loadData = byteAccess ? {24'd0, loadByte} : rawRead;

endmodule

// File: datapath/barrelShifter.sv
`timescale 1ns/1ps

module barrelShifter (
  input  logic          [31:0] value,
  input  armPkg::shiftT        shiftType,
  input  logic          [4:0]  amount,
  input  logic                 immForm,
  output logic          [31:0] result
);
  import armPkg::*;

  logic [63:0] immPair;
  logic [63:0] regPair;
  logic [4:0]  immRot;

  // Rotate right done as a right shift of the doubled word
  assign immRot  = {value[11:8], 1'b0};
  assign immPair = {24'd0, value[7:0], 24'd0, value[7:0]} >> immRot;
  assign regPair = {value, value} >> amount;

  always_comb begin
    if (immForm) begin
      // Rotated 8-bit immediate
      result = immPair[31:0];
    end else begin
      case (shiftType)
        ShLsl: result = value << amount;
        // #0 encodes a shift by 32
        ShLsr: result = (amount == 5'd0) ? 32'd0 : value >> amount;
        ShAsr: result = (amount == 5'd0) ? {32{value[31]}} :
                                           32'($signed(value) >>> amount);
        // RRX not supported, #0 passes through
        ShRor: result = regPair[31:0];
        default: result = value;
      endcase
    end
  end

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                   clk,
  input  logic                   we,
  input  armPkg::regAddrT        ra1,
  input  armPkg::regAddrT        ra2,
  input  armPkg::regAddrT        wa,
  input  logic            [31:0] wd,
  input  logic            [31:0] pcPlus8,
  output logic            [31:0] rd1,
  output logic            [31:0] rd2
);
  import armPkg::*;

  // R0 to R14 only
  logic [31:0] regs [0:14];

  // PC writes are out of scope, R15 writes dropped
  always_ff @(posedge clk) begin
    if (we && wa != PcReg) begin
      regs[wa] <= wd;
    end
  end

  // Read port
  // R15 gives PC+8, same-cycle write passes straight through
  function automatic logic [31:0] readPort(input regAddrT ra);
    if (ra == PcReg) begin
      return pcPlus8;
    end else if (we && wa == ra) begin
      return wd;
    end
    return regs[ra];
  endfunction

  assign rd1 = readPort(ra1);
  assign rd2 = readPort(ra2);

endmodule

// File: datapath/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    en,
  input  logic    clr,
  input  payloadT d,
  output payloadT q
);

  // Clear beats enable, a cleared stage is a bubble
  always_ff @(posedge clk) begin
    if (!rstN || clr) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: common/armPkg.sv
package armPkg;

  // Register number, R15 reads as PC+8
  typedef logic [3:0] regAddrT;

  localparam regAddrT PcReg = 4'd15;

  // Data-processing opcodes of the subset, encoded as in instr[24:21]
  typedef enum logic [3:0] {
    AluAnd = 4'b0000,
    AluEor = 4'b0001,
    AluSub = 4'b0010,
    AluRsb = 4'b0011,
    AluAdd = 4'b0100,
    AluOrr = 4'b1100,
    AluMov = 4'b1101,
    AluBic = 4'b1110
  } aluOpT;

  // Shift type, encoded as in instr[6:5]
  typedef enum logic [1:0] {
    ShLsl = 2'b00,
    ShLsr = 2'b01,
    ShAsr = 2'b10,
    ShRor = 2'b11
  } shiftT;

  // Per-instruction control word, all zero is a bubble
  typedef struct packed {
    logic  regWrite;
    logic  memWrite;
    logic  memToReg;
    logic  byteAccess;
    logic  immOperand;  // Rotated 8-bit immediate as operand 2
    logic  memOffset;   // Result is base +/- 12-bit offset
    logic  offsetUp;
    logic  branch;
    aluOpT aluOp;
  } ctrlT;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;       // Raw 12-bit field or shifted branch offset
    regAddrT     ra1;
    regAddrT     ra2;
    regAddrT     wa;
    shiftT       shiftType;
    logic [4:0]  shiftAmt;
    logic [31:0] pcPlus8;
  } execStageT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] aluOut;
    logic [31:0] writeData;
    regAddrT     wa;
  } memStageT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] aluOut;
    logic [31:0] readData;
    regAddrT     wa;
  } wbStageT;

endpackage
